/* run.sh */
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/rv_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulator output"
exit 1

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_chk.sv
rv_core_tb.sv

/* rv_core.sv */
/*
 * rv_core
 * Single-issue RV32I integer pipeline: decode, execute, result
 */
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_instr_valid,
	input  instr_t    i_instr,
	output logic      o_wb_valid,
	output reg_addr_t o_wb_rd,
	output word_t     o_wb_data
);

	// Decode to execute
	logic      id_valid;
	reg_addr_t id_rd;
	alu_op_t   id_op;
	word_t     id_a;
	word_t     id_b;

	// Execute to result, plus the forwarding path
	word_t     ex_alu_data;
	logic      ex_valid;
	reg_addr_t ex_rd;
	word_t     ex_data;

	// Register file read ports
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;

	rv_decode rv_decode_i (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_rs1_data    (rs1_data),
		.i_rs2_data    (rs2_data),
		.i_ex_alu_data (ex_alu_data),
		.o_rs1_addr    (rs1_addr),
		.o_rs2_addr    (rs2_addr),
		.o_id_valid    (id_valid),
		.o_id_rd       (id_rd),
		.o_id_op       (id_op),
		.o_id_a        (id_a),
		.o_id_b        (id_b)
	);

	rv_execute rv_execute_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_id_valid (id_valid),
		.i_id_rd    (id_rd),
		.i_id_op    (id_op),
		.i_id_a     (id_a),
		.i_id_b     (id_b),
		.o_alu_data (ex_alu_data),
		.o_ex_valid (ex_valid),
		.o_ex_rd    (ex_rd),
		.o_ex_data  (ex_data)
	);

	rv_result rv_result_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_ex_valid (ex_valid),
		.i_ex_rd    (ex_rd),
		.i_ex_data  (ex_data),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.o_wb_valid (o_wb_valid),
		.o_wb_rd    (o_wb_rd),
		.o_wb_data  (o_wb_data)
	);

endmodule

/* rv_core_chk.sv */
/*
 * rv_core_chk
 * Port-level assertions on rv_core, bound into every instance
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_chk import rv_core_pkg::*; (
	input logic   clk,
	input logic   i_rst_n,
	input logic   i_instr_valid,
	input instr_t i_instr,
	input logic   o_wb_valid
);

	logic legal_opc;

	assign legal_opc = (i_instr[6:0] == `RV_OPC_OP) || (i_instr[6:0] == `RV_OPC_OPIMM) ||
		(i_instr[6:0] == `RV_OPC_LUI);

	// Nothing retires while reset is held
	a_idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> !o_wb_valid)
		else $error("o_wb_valid high during reset");

	// Fixed two-edge latency from acceptance to writeback
	a_legal_retires: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_instr_valid && legal_opc) |-> ##2 o_wb_valid)
		else $error("legal instruction did not retire two edges later");

	a_illegal_bubble: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_instr_valid && !legal_opc) |-> ##2 !o_wb_valid)
		else $error("unsupported opcode produced a retirement");

endmodule

bind rv_core rv_core_chk rv_core_chk_i (.*);

/* rv_core_macros.svh */
/*
 * RV32I pipeline constants
 * Widths, accepted opcodes and ALU operation codes
 */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define RV_XLEN        32
`define RV_ILEN        32
`define RV_REG_ADDR_W  5
`define RV_ALU_OP_W    4

// Major opcodes handled by decode
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_LUI     7'b0110111

`define RV_ALU_ADD     4'd0
`define RV_ALU_SUB     4'd1
`define RV_ALU_SLL     4'd2
`define RV_ALU_SLT     4'd3
`define RV_ALU_SLTU    4'd4
`define RV_ALU_XOR     4'd5
`define RV_ALU_SRL     4'd6
`define RV_ALU_SRA     4'd7
`define RV_ALU_OR      4'd8
`define RV_ALU_AND     4'd9

`endif

/* rv_core_pkg.sv */
/*
 * rv_core_pkg
 * Vector types shared by the stages of the RV32I pipeline
 */
`include "rv_core_macros.svh"

package rv_core_pkg;

	// Data word of the integer datapath
	typedef logic [`RV_XLEN-1:0] word_t;

	// Index into the 32-entry register file
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	// Raw instruction as it arrives on the input port
	typedef logic [`RV_ILEN-1:0] instr_t;

	// ALU operation, see RV_ALU_* codes
	typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;

endpackage

/* rv_core_tb.sv */
/*
 * rv_core_tb
 * Random-stimulus testbench for the RV32I pipeline with a reference
 * register model, an expected-retirement queue and a watchdog
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_tb;

	localparam int N_RAND  = 200;
	localparam int N_CHAIN = 200;
	localparam int N_LUI   = 120;
	localparam int N_X0    = 120;
	// Longest gap is 3 idle cycles plus drain time for five tests
	localparam int MAX_CYCLES = 3 + 5 + 31 + N_RAND * 4 + N_CHAIN + N_LUI + N_X0 * 2 + 5 * 10;

	logic        clk;
	logic        i_rst_n;
	logic        i_instr_valid;
	logic [31:0] i_instr;
	logic        o_wb_valid;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;

	int          seed;
	int          edge_cnt;
	int          errors;
	int          err_start;
	int          retired;
	int          n_sent;
	int          test_cnt;
	string       cur_test;
	logic [31:0] model_regs [32];

	// Expected retirements in program order
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	int          exp_edge [$];
	string       exp_test [$];
	logic [4:0]  e_rd;
	logic [31:0] e_data;
	int          e_edge;
	string       e_test;

	rv_core rv_core_i (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.o_wb_valid    (o_wb_valid),
		.o_wb_rd       (o_wb_rd),
		.o_wb_data     (o_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	initial begin
		#(MAX_CYCLES * 10 * 2 + 500);
		$display("timeout: pipeline stopped retiring, %0d results still pending", exp_rd.size());
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	function automatic logic [4:0] rand_nz_reg();
		logic [31:0] r;
		r = rand_word();
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, `RV_OPC_OPIMM};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `RV_OPC_LUI};
	endfunction

	// Random OP or OP-IMM with only legal funct7 values
	function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r  = rand_word();
		f3 = r[2:0];
		f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[4]) ? 7'h20 : 7'h00;
		if (r[3])
			return enc_r(f7, rs2, rs1, f3, rd);
		if (f3 == 3'd1 || f3 == 3'd5)
			return enc_i({(f3 == 3'd5) ? f7 : 7'h00, r[9:5]}, rs1, f3, rd);
		return enc_i(r[31:20], rs1, f3, rd);
	endfunction

	// RV32I integer semantics by funct3
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] r;
		sh = b[4:0];
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << sh;
			// Sign bits differ means the negative one is smaller
			3'd2: r = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
			3'd3: r = {31'd0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				r = a >> sh;
				if (alt && a[31])
					r = r | ~(32'hffffffff >> sh);
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic void model_step(input logic [31:0] ins, output logic ok,
		output logic [4:0] rd, output logic [31:0] val);
		logic [2:0]  f3;
		logic [31:0] a;
		f3  = ins[14:12];
		rd  = ins[11:7];
		a   = model_regs[ins[19:15]];
		ok  = 1'b1;
		val = 32'd0;
		if (ins[6:0] == `RV_OPC_LUI)
			val = {ins[31:12], 12'h000};
		else if (ins[6:0] == `RV_OPC_OP)
			val = alu_ref(f3, ins[30], a, model_regs[ins[24:20]]);
		else if (ins[6:0] == `RV_OPC_OPIMM)
			val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, {{20{ins[31]}}, ins[31:20]});
		else
			ok = 1'b0;
	endfunction

	task automatic send(input logic [31:0] ins);
		logic        ok;
		logic [4:0]  rd;
		logic [31:0] val;
		@(negedge clk);
		i_instr_valid = 1'b1;
		i_instr       = ins;
		n_sent++;
		model_step(ins, ok, rd, val);
		if (ok) begin
			exp_rd.push_back(rd);
			exp_data.push_back(val);
			exp_edge.push_back(edge_cnt + 2);
			exp_test.push_back(cur_test);
			if (rd != 5'd0)
				model_regs[rd] = val;
		end
	endtask

	task automatic gap(input int n);
		repeat (n) begin
			@(negedge clk);
			i_instr_valid = 1'b0;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		err_start = errors;
		n_sent    = 0;
	endtask

	task automatic end_test();
		gap(1);
		while (exp_rd.size() != 0)
			@(negedge clk);
		gap(3);
		test_cnt++;
		$display("test %s: %0d sent, %0d errors, %s", cur_test, n_sent, errors - err_start,
			(errors == err_start) ? "ok" : "FAILED");
	endtask

	// Each retirement against the head of the expected queue
	always @(negedge clk) begin
		if (o_wb_valid) begin
			if (exp_rd.size() == 0) begin
				$display("error: x%0d retired with no instruction pending", o_wb_rd);
				errors++;
			end else begin
				e_rd   = exp_rd.pop_front();
				e_data = exp_data.pop_front();
				e_edge = exp_edge.pop_front();
				e_test = exp_test.pop_front();
				retired++;
				if (edge_cnt != e_edge) begin
					$display("error: %s retired at edge %0d instead of edge %0d",
						e_test, edge_cnt, e_edge);
					errors++;
				end
				if (o_wb_rd != e_rd) begin
					$display("mismatch %s rd: expected %0d, actual %0d", e_test, e_rd, o_wb_rd);
					errors++;
				end
				if (o_wb_data != e_data) begin
					$display("mismatch %s data x%0d: expected %h, actual %h",
						e_test, e_rd, e_data, o_wb_data);
					errors++;
				end
			end
		end
	end

	task automatic reset_read();
		logic [4:0] ri;
		begin_test("reset_read");
		gap(5);
		for (int i = 1; i < 32; i++) begin
			ri = i[4:0];
			send(enc_r(7'h00, ri, ri, 3'd0, ri));
		end
		end_test();
	endtask

	task automatic random_indep();
		logic [31:0] r;
		begin_test("random_indep");
		for (int i = 0; i < N_RAND; i++) begin
			r = rand_word();
			send(rand_alu(rand_nz_reg(), r[4:0], r[9:5]));
			gap(rand_word() % 4);
		end
		end_test();
	endtask

	task automatic dep_chain();
		logic [4:0] prev1;
		logic [4:0] prev2;
		logic [4:0] rd;
		begin_test("dep_chain");
		prev1 = rand_nz_reg();
		prev2 = rand_nz_reg();
		for (int i = 0; i < N_CHAIN; i++) begin
			rd = rand_nz_reg();
			send(rand_alu(rd, prev1, prev2));
			prev2 = prev1;
			prev1 = rd;
		end
		end_test();
	endtask

	task automatic lui_shift();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		begin_test("lui_shift");
		for (int i = 0; i < N_LUI; i++) begin
			r   = rand_word();
			rd  = rand_nz_reg();
			rs1 = rand_nz_reg();
			rs2 = rand_nz_reg();
			f3  = r[2] ? 3'd5 : 3'd1;
			f7  = (r[2] && r[3]) ? 7'h20 : 7'h00;
			case (r[1:0])
				2'd0: send(enc_u(r[31:12], rd));
				2'd1: begin
					if (r[4])
						send(enc_r(f7, rs2, rs1, f3, rd));
					else
						send(enc_i({f7, r[9:5]}, rs1, f3, rd));
				end
				2'd2: send(enc_r(7'h00, rs2, rs1, r[5] ? 3'd3 : 3'd2, rd));
				default: send(enc_i(r[31:20], rs1, r[5] ? 3'd3 : 3'd2, rd));
			endcase
		end
		end_test();
	endtask

	task automatic x0_illegal();
		logic [31:0] r;
		logic [31:0] ins;
		begin_test("x0_illegal");
		for (int i = 0; i < N_X0; i++) begin
			r   = rand_word();
			ins = rand_word();
			case (r[1:0])
				2'd0: send(rand_alu(5'd0, rand_nz_reg(), rand_nz_reg()));
				2'd1: send(rand_alu(rand_nz_reg(), 5'd0, r[3] ? 5'd0 : rand_nz_reg()));
				2'd2: begin
					// Load, store, branch and AUIPC are not decoded
					case (r[5:4])
						2'd0: ins[6:0] = 7'b0000011;
						2'd1: ins[6:0] = 7'b0100011;
						2'd2: ins[6:0] = 7'b1100011;
						default: ins[6:0] = 7'b0010111;
					endcase
					send(ins);
				end
				default: send(rand_alu(rand_nz_reg(), rand_nz_reg(), rand_nz_reg()));
			endcase
			gap(r[8] ? 1 : 0);
		end
		end_test();
	endtask

	initial begin
		seed          = 32'h88eb;
		i_rst_n       = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = 32'd0;
		edge_cnt      = 0;
		errors        = 0;
		retired       = 0;
		test_cnt      = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		reset_read();
		random_indep();
		dep_chain();
		lui_shift();
		x0_illegal();

		$display("summary: %0d tests, %0d retired, %0d errors", test_cnt, retired, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* rv_decode.sv */
/*
 * rv_decode
 * Decode stage: opcode check, ALU op mapping, immediates, operand
 * forwarding from execute and the decode/execute register
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_decode import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_instr_valid,
	input  instr_t    i_instr,
	input  word_t     i_rs1_data,
	input  word_t     i_rs2_data,
	input  word_t     i_ex_alu_data,
	output reg_addr_t o_rs1_addr,
	output reg_addr_t o_rs2_addr,
	output logic      o_id_valid,
	output reg_addr_t o_id_rd,
	output alu_op_t   o_id_op,
	output word_t     o_id_a,
	output word_t     o_id_b
);

	// Instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_b5;
	reg_addr_t  rd;
	reg_addr_t  rs1;
	reg_addr_t  rs2;

	logic    is_op;
	logic    is_opimm;
	logic    is_lui;
	logic    dec_valid;
	alu_op_t dec_op;

	word_t imm_i;
	word_t imm_u;
	word_t rs1_val;
	word_t rs2_val;
	word_t dec_a;
	word_t dec_b;

	assign opcode    = i_instr[6:0];
	assign rd        = i_instr[11:7];
	assign funct3    = i_instr[14:12];
	assign rs1       = i_instr[19:15];
	assign rs2       = i_instr[24:20];
	assign funct7_b5 = i_instr[30];

	assign is_op     = (opcode == `RV_OPC_OP);
	assign is_opimm  = (opcode == `RV_OPC_OPIMM);
	assign is_lui    = (opcode == `RV_OPC_LUI);
	// Unsupported opcodes turn into a bubble
	assign dec_valid = i_instr_valid & (is_op | is_opimm | is_lui);

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'b0};

	always_comb begin
		case (funct3)
			3'b000:  dec_op = (is_op && funct7_b5) ? `RV_ALU_SUB : `RV_ALU_ADD;
			3'b001:  dec_op = `RV_ALU_SLL;
			3'b010:  dec_op = `RV_ALU_SLT;
			3'b011:  dec_op = `RV_ALU_SLTU;
			3'b100:  dec_op = `RV_ALU_XOR;
			// srai and sra share funct7 bit 5
			3'b101:  dec_op = funct7_b5 ? `RV_ALU_SRA : `RV_ALU_SRL;
			3'b110:  dec_op = `RV_ALU_OR;
			default: dec_op = `RV_ALU_AND;
		endcase
		// LUI is zero plus the upper immediate
		if (is_lui)
			dec_op = `RV_ALU_ADD;
	end

	assign o_rs1_addr = rs1;
	assign o_rs2_addr = rs2;

	// Younger result in execute wins over the register file read
	assign rs1_val = (o_id_valid && o_id_rd != '0 && o_id_rd == rs1) ? i_ex_alu_data : i_rs1_data;
	assign rs2_val = (o_id_valid && o_id_rd != '0 && o_id_rd == rs2) ? i_ex_alu_data : i_rs2_data;

	assign dec_a = is_lui ? '0 : rs1_val;
	assign dec_b = is_op ? rs2_val : (is_lui ? imm_u : imm_i);

	// Decode/execute register
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_id_valid <= 1'b0;
			o_id_rd    <= '0;
			o_id_op    <= '0;
			o_id_a     <= '0;
			o_id_b     <= '0;
		end else begin
			o_id_valid <= dec_valid;
			o_id_rd    <= rd;
			o_id_op    <= dec_op;
			o_id_a     <= dec_a;
			o_id_b     <= dec_b;
		end
	end

endmodule

/* rv_execute.sv */
/*
 * rv_execute
 * Execute stage: ten-operation ALU, combinational result for
 * forwarding and the execute/result register
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_execute import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_id_valid,
	input  reg_addr_t i_id_rd,
	input  alu_op_t   i_id_op,
	input  word_t     i_id_a,
	input  word_t     i_id_b,
	output word_t     o_alu_data,
	output logic      o_ex_valid,
	output reg_addr_t o_ex_rd,
	output word_t     o_ex_data
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;
	word_t      alu_res;

	// Shift amount is the low five bits of operand b
	assign shamt       = i_id_b[4:0];
	assign lt_signed   = $signed(i_id_a) < $signed(i_id_b);
	assign lt_unsigned = i_id_a < i_id_b;

	always_comb begin
		case (i_id_op)
			`RV_ALU_ADD:  alu_res = i_id_a + i_id_b;
			`RV_ALU_SUB:  alu_res = i_id_a - i_id_b;
			`RV_ALU_SLL:  alu_res = i_id_a << shamt;
			`RV_ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			`RV_ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			`RV_ALU_XOR:  alu_res = i_id_a ^ i_id_b;
			`RV_ALU_SRL:  alu_res = i_id_a >> shamt;
			`RV_ALU_SRA:  alu_res = $signed(i_id_a) >>> shamt;
			`RV_ALU_OR:   alu_res = i_id_a | i_id_b;
			`RV_ALU_AND:  alu_res = i_id_a & i_id_b;
			default:      alu_res = '0;
		endcase
	end

	// Back to decode for the next instruction's operands
	assign o_alu_data = alu_res;

	// Execute/result register
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ex_valid <= 1'b0;
			o_ex_rd    <= '0;
			o_ex_data  <= '0;
		end else begin
			o_ex_valid <= i_id_valid;
			o_ex_rd    <= i_id_rd;
			o_ex_data  <= alu_res;
		end
	end

endmodule

/* rv_result.sv */
/*
 * rv_result
 * Result stage: x1..x31 register file with write-through bypass,
 * and the writeback port of the retiring instruction
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_result import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_ex_valid,
	input  reg_addr_t i_ex_rd,
	input  word_t     i_ex_data,
	input  reg_addr_t i_rs1_addr,
	input  reg_addr_t i_rs2_addr,
	output word_t     o_rs1_data,
	output word_t     o_rs2_data,
	output logic      o_wb_valid,
	output reg_addr_t o_wb_rd,
	output word_t     o_wb_data
);

	// x0 has no storage
	word_t regs [1:31];
	logic  wr_en;

	assign wr_en = i_ex_valid && (i_ex_rd != '0);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[i_ex_rd] <= i_ex_data;
		end
	end

	// Pending write shows through to a same-cycle read
	always_comb begin
		if (i_rs1_addr == '0)
			o_rs1_data = '0;
		else if (wr_en && i_rs1_addr == i_ex_rd)
			o_rs1_data = i_ex_data;
		else
			o_rs1_data = regs[i_rs1_addr];
	end

	always_comb begin
		if (i_rs2_addr == '0)
			o_rs2_data = '0;
		else if (wr_en && i_rs2_addr == i_ex_rd)
			o_rs2_data = i_ex_data;
		else
			o_rs2_data = regs[i_rs2_addr];
	end

	// Retirement, including writes aimed at x0
	assign o_wb_valid = i_ex_valid;
	assign o_wb_rd    = i_ex_rd;
	assign o_wb_data  = i_ex_data;

endmodule
